//--- hw/agc_reg_pkg.sv
// Register file types and constants
package agc_reg_pkg;

  // Machine word width
  localparam int WORD_W = 15;

  typedef logic [WORD_W-1:0] word_t;

  // Register selects for both read ports and the write port
  typedef enum logic [3:0] {
    A    = 4'd0,
    L    = 4'd1,
    Q    = 4'd2,
    EB   = 4'd3,
    FB   = 4'd4,
    BB   = 4'd5,
    ZERO = 4'd6,
    CYR  = 4'd7,
    SR   = 4'd8,
    CYL  = 4'd9,
    SL   = 4'd10
  } reg_sel_t;

  // Bank field positions inside a word
  localparam int BANK_W = 3;
  localparam int EB_LSB = 9;
  localparam int FB_LSB = 12;

  typedef logic [BANK_W-1:0] bank_num_t;

  // Shared bank bits behind EB, FB and BB
  typedef struct packed {
    bank_num_t eb;
    bank_num_t fb;
  } bank_bits_t;

  // Register write request
  typedef struct packed {
    logic     en;
    reg_sel_t sel;
    word_t    data;
  } reg_write_t;

endpackage

//--- hw/agc_addr_pkg.sv
// Address map types and constants
package agc_addr_pkg;

  localparam int SOFT_ADDR_W = 12;
  localparam int ROM_ADDR_W  = 14;
  localparam int RAM_ADDR_W  = 11;

  typedef logic [SOFT_ADDR_W-1:0] soft_addr_t;
  typedef logic [ROM_ADDR_W-1:0]  rom_addr_t;
  typedef logic [RAM_ADDR_W-1:0]  ram_addr_t;

  // Software address map
  // Below ERASABLE_TOP is erasable, the rest is fixed
  localparam soft_addr_t ERASABLE_TOP         = 12'o2000;
  localparam soft_addr_t FIXED_FIXED_BASE     = 12'o4000;
  localparam soft_addr_t BANKED_ERASABLE_BASE = 12'o1400;

  // Bank sizes in words
  localparam ram_addr_t E_BANK_WORDS = 11'o0400;
  localparam rom_addr_t F_BANK_WORDS = 14'o02000;

  // Full erasable memory depth
  localparam int RAM_WORDS = 2048;

  // Erasable write request, addressed in software space
  typedef struct packed {
    logic               en;
    soft_addr_t         addr;
    agc_reg_pkg::word_t data;
  } mem_write_t;

endpackage

//--- hw/central_regs.sv
// Central and editing registers
`timescale 1ns/1ps

module central_regs (
  input  logic                    clk,
  input  logic                    rst_l,
  input  agc_reg_pkg::reg_write_t wr,
  input  agc_reg_pkg::reg_sel_t   rd1_sel,
  input  agc_reg_pkg::reg_sel_t   rd2_sel,
  output agc_reg_pkg::word_t      rd1_data,
  output agc_reg_pkg::word_t      rd2_data,
  output agc_reg_pkg::bank_bits_t bank
);

  import agc_reg_pkg::*;

  word_t      a_q;
  word_t      l_q;
  word_t      q_q;
  word_t      cyr_q;
  word_t      sr_q;
  word_t      cyl_q;
  word_t      sl_q;
  bank_bits_t bank_q;

  // Value the selected register holds after this edge
  bank_bits_t bank_nxt;
  word_t      wr_val;

  // Read view of every select, indexed by reg_sel_t
  word_t      stored_view [16];

  // Bank fields placed back at their word positions
  function automatic word_t bank_view(input reg_sel_t sel, input bank_bits_t b);
    word_t eb_w;
    word_t fb_w;
    eb_w = word_t'(b.eb) << EB_LSB;
    fb_w = word_t'(b.fb) << FB_LSB;
    case (sel)
      EB:      return eb_w;
      FB:      return fb_w;
      BB:      return eb_w | fb_w;
      default: return '0;
    endcase
  endfunction

  always_comb begin
    bank_nxt = bank_q;
    case (wr.sel)
      EB: bank_nxt.eb = wr.data[EB_LSB +: BANK_W];
      FB: bank_nxt.fb = wr.data[FB_LSB +: BANK_W];
      BB: begin
        bank_nxt.eb = wr.data[EB_LSB +: BANK_W];
        bank_nxt.fb = wr.data[FB_LSB +: BANK_W];
      end
      default: ;
    endcase
  end

  // Editing registers keep a shifted copy of the word
  always_comb begin
    case (wr.sel)
      A, L, Q:    wr_val = wr.data;
      EB, FB, BB: wr_val = bank_view(wr.sel, bank_nxt);
      CYR:        wr_val = {wr.data[0], wr.data[14:1]};
      SR:         wr_val = {wr.data[14], wr.data[14:1]};
      CYL:        wr_val = {wr.data[13:0], wr.data[14]};
      SL:         wr_val = {wr.data[13:0], 1'b0};
      default:    wr_val = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      a_q    <= '0;
      l_q    <= '0;
      q_q    <= '0;
      cyr_q  <= '0;
      sr_q   <= '0;
      cyl_q  <= '0;
      sl_q   <= '0;
      bank_q <= '0;
    end else if (wr.en) begin
      case (wr.sel)
        A:          a_q    <= wr_val;
        L:          l_q    <= wr_val;
        Q:          q_q    <= wr_val;
        EB, FB, BB: bank_q <= bank_nxt;
        CYR:        cyr_q  <= wr_val;
        SR:         sr_q   <= wr_val;
        CYL:        cyl_q  <= wr_val;
        SL:         sl_q   <= wr_val;
        default: ;  // ZERO and unused codes drop the write
      endcase
    end
  end

  always_comb begin
    stored_view     = '{default: '0};
    stored_view[A]  = a_q;
    stored_view[L]  = l_q;
    stored_view[Q]  = q_q;
    stored_view[EB] = bank_view(EB, bank_q);
    stored_view[FB] = bank_view(FB, bank_q);
    stored_view[BB] = bank_view(BB, bank_q);
    stored_view[CYR] = cyr_q;
    stored_view[SR]  = sr_q;
    stored_view[CYL] = cyl_q;
    stored_view[SL]  = sl_q;
  end

  // Same-cycle bypass of the pending write
  assign rd1_data = (wr.en && (rd1_sel == wr.sel)) ? wr_val : stored_view[rd1_sel];
  assign rd2_data = (wr.en && (rd2_sel == wr.sel)) ? wr_val : stored_view[rd2_sel];

  assign bank = bank_q;

endmodule

//--- hw/bank_translate.sv
// Software to memory address translation
`timescale 1ns/1ps

module bank_translate (
  input  agc_addr_pkg::soft_addr_t addr,
  input  agc_reg_pkg::bank_bits_t  bank,
  output agc_addr_pkg::rom_addr_t  rom_addr,
  output agc_addr_pkg::ram_addr_t  ram_addr,
  output logic                     is_fixed
);

  import agc_addr_pkg::*;

  // Everything from ERASABLE_TOP up is fixed memory
  assign is_fixed = (addr >= ERASABLE_TOP);

  always_comb begin
    rom_addr = '0;
    ram_addr = '0;
    if (addr >= FIXED_FIXED_BASE) begin
      rom_addr = rom_addr_t'(addr - FIXED_FIXED_BASE);
    end else if (is_fixed) begin
      // Fixed bank picked by FB
      rom_addr = rom_addr_t'(bank.fb) * F_BANK_WORDS
                 + rom_addr_t'(addr - ERASABLE_TOP);
    end else if (addr >= BANKED_ERASABLE_BASE) begin
      // Erasable bank picked by EB
      ram_addr = ram_addr_t'(bank.eb) * E_BANK_WORDS
                 + ram_addr_t'(addr - BANKED_ERASABLE_BASE);
    end else begin
      ram_addr = ram_addr_t'(addr);
    end
  end

endmodule

//--- hw/erasable_mem.sv
// Erasable word memory
`timescale 1ns/1ps

module erasable_mem #(
  parameter int RAM_WORDS = agc_addr_pkg::RAM_WORDS
) (
  input  logic                    clk,
  input  logic                    wr_en,
  input  agc_addr_pkg::ram_addr_t wr_addr,
  input  agc_addr_pkg::ram_addr_t rd_addr,
  input  agc_reg_pkg::word_t      wr_data,
  output agc_reg_pkg::word_t      rd_data
);

  import agc_reg_pkg::*;

  // Index width, smaller depths wrap on the low bits
  localparam int IDX_W = $clog2(RAM_WORDS);

  word_t mem [RAM_WORDS];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr[IDX_W-1:0]] <= wr_data;
    end
  end

  // Read sees the stored word, no write bypass
  assign rd_data = mem[rd_addr[IDX_W-1:0]];

endmodule

//--- hw/agc_mem_core.sv
// Memory side datapath top level
`timescale 1ns/1ps

module agc_mem_core #(
  parameter int RAM_WORDS = agc_addr_pkg::RAM_WORDS
) (
  input  logic                     clk,
  input  logic                     rst_l,
  input  agc_reg_pkg::reg_write_t  reg_wr,
  input  agc_reg_pkg::reg_sel_t    rd1_sel,
  input  agc_reg_pkg::reg_sel_t    rd2_sel,
  input  agc_addr_pkg::soft_addr_t fetch_addr,
  input  agc_addr_pkg::soft_addr_t rd_addr,
  input  agc_addr_pkg::mem_write_t mem_wr,
  output agc_reg_pkg::word_t       rd1_data,
  output agc_reg_pkg::word_t       rd2_data,
  output agc_addr_pkg::rom_addr_t  fetch_rom_addr,
  output agc_addr_pkg::rom_addr_t  rd_rom_addr,
  output logic                     rd_is_fixed,
  output agc_reg_pkg::word_t       rd_ram_data
);

  import agc_reg_pkg::*;
  import agc_addr_pkg::*;

  bank_bits_t bank;
  ram_addr_t  rd_ram_addr;
  ram_addr_t  wr_ram_addr;
  logic       wr_is_fixed;
  logic       ram_wr_en;

  central_regs i_central_regs (
    .clk      (clk),
    .rst_l    (rst_l),
    .wr       (reg_wr),
    .rd1_sel  (rd1_sel),
    .rd2_sel  (rd2_sel),
    .rd1_data (rd1_data),
    .rd2_data (rd2_data),
    .bank     (bank)
  );

  // Instruction fetch only ever targets fixed memory
  bank_translate i_fetch_translate (
    .addr     (fetch_addr),
    .bank     (bank),
    .rom_addr (fetch_rom_addr),
    .ram_addr (),
    .is_fixed ()
  );

  bank_translate i_rd_translate (
    .addr     (rd_addr),
    .bank     (bank),
    .rom_addr (rd_rom_addr),
    .ram_addr (rd_ram_addr),
    .is_fixed (rd_is_fixed)
  );

  bank_translate i_wr_translate (
    .addr     (mem_wr.addr),
    .bank     (bank),
    .rom_addr (),
    .ram_addr (wr_ram_addr),
    .is_fixed (wr_is_fixed)
  );

  // Fixed memory is read only
  assign ram_wr_en = mem_wr.en & ~wr_is_fixed;

  erasable_mem #(
    .RAM_WORDS (RAM_WORDS)
  ) i_erasable_mem (
    .clk     (clk),
    .wr_en   (ram_wr_en),
    .wr_addr (wr_ram_addr),
    .rd_addr (rd_ram_addr),
    .wr_data (mem_wr.data),
    .rd_data (rd_ram_data)
  );

endmodule

//--- testbench/tb_agc_mem_core.sv
// Memory side datapath testbench
`timescale 1ns/1ps

module tb_agc_mem_core;

  import agc_reg_pkg::*;
  import agc_addr_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int EDIT_ROUNDS  = 4;
  localparam int FIXED_ROUNDS = 4;
  localparam int FIXED_ADDRS  = 16;
  localparam int ERAS_ROUNDS  = 4;

  // Cycle budget of each test, for the watchdog
  localparam int RESET_TEST_CYCLES = 2;
  localparam int REG_TEST_CYCLES   = 10;
  localparam int EDIT_TEST_CYCLES  = EDIT_ROUNDS * 8;
  localparam int BANK_TEST_CYCLES  = 3 * 3 * 2;
  localparam int FIXED_TEST_CYCLES = FIXED_ROUNDS * (FIXED_ADDRS + 2);
  localparam int ERAS_TEST_CYCLES  = ERAS_ROUNDS * 8 + 2;
  localparam int TOTAL_CYCLES = RESET_CYCLES + RESET_TEST_CYCLES + REG_TEST_CYCLES +
                                EDIT_TEST_CYCLES + BANK_TEST_CYCLES + FIXED_TEST_CYCLES +
                                ERAS_TEST_CYCLES;
  localparam int MARGIN_CYCLES = 100;
  localparam int WATCHDOG_NS   = (TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic       clk;
  logic       rst_l;
  reg_write_t reg_wr;
  reg_sel_t   rd1_sel;
  reg_sel_t   rd2_sel;
  soft_addr_t fetch_addr;
  soft_addr_t rd_addr;
  mem_write_t mem_wr;
  word_t      rd1_data;
  word_t      rd2_data;
  rom_addr_t  fetch_rom_addr;
  rom_addr_t  rd_rom_addr;
  logic       rd_is_fixed;
  word_t      rd_ram_data;

  integer seed;
  int     err_count;
  int     tests_run;
  int     tests_failed;
  int     test_errs_start;
  string  test_name;

  // Expected bank fields
  int exp_eb;
  int exp_fb;

  reg_sel_t all_sels [11] = '{A, L, Q, EB, FB, BB, ZERO, CYR, SR, CYL, SL};

  agc_mem_core #(
    .RAM_WORDS (RAM_WORDS)
  ) i_agc_mem_core (
    .clk            (clk),
    .rst_l          (rst_l),
    .reg_wr         (reg_wr),
    .rd1_sel        (rd1_sel),
    .rd2_sel        (rd2_sel),
    .fetch_addr     (fetch_addr),
    .rd_addr        (rd_addr),
    .mem_wr         (mem_wr),
    .rd1_data       (rd1_data),
    .rd2_data       (rd2_data),
    .fetch_rom_addr (fetch_rom_addr),
    .rd_rom_addr    (rd_rom_addr),
    .rd_is_fixed    (rd_is_fixed),
    .rd_ram_data    (rd_ram_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      err_count++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs_start = err_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count == test_errs_start) begin
      $display("%s: ok", test_name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", test_name, err_count - test_errs_start);
    end
  endtask

  task automatic write_reg(input reg_sel_t sel, input word_t data);
    next_cycle();
    reg_wr.en   = 1'b1;
    reg_wr.sel  = sel;
    reg_wr.data = data;
  endtask

  task automatic drop_write();
    next_cycle();
    reg_wr.en = 1'b0;
    mem_wr.en = 1'b0;
  endtask

  // Rotate and shift results from arithmetic on a wide copy
  function automatic word_t edit_value(input reg_sel_t sel, input word_t d);
    logic [31:0] w;
    w = d;
    case (sel)
      CYR:     return word_t'((w >> 1) | ((w & 1) << 14));
      SR:      return word_t'((w >> 1) | (w & 32'h4000));
      CYL:     return word_t'(((w << 1) | (w >> 14)) & 32'h7fff);
      SL:      return word_t'((w << 1) & 32'h7fff);
      default: return d;
    endcase
  endfunction

  function automatic word_t bank_word(input reg_sel_t sel);
    case (sel)
      EB:      return word_t'(exp_eb << 9);
      FB:      return word_t'(exp_fb << 12);
      default: return word_t'((exp_eb << 9) | (exp_fb << 12));
    endcase
  endfunction

  function automatic logic [31:0] expect_rom(input int addr, input int fb);
    if (addr >= 'o4000) return addr - 'o4000;
    if (addr >= 'o2000) return fb * 'o2000 + addr - 'o2000;
    return 0;
  endfunction

  task automatic test_reset();
    start_test("reset");
    next_cycle();
    foreach (all_sels[i]) begin
      rd1_sel = all_sels[i];
      rd2_sel = all_sels[i];
      #1;
      check($sformatf("rd1 sel %0d", i), 0, rd1_data);
      check($sformatf("rd2 sel %0d", i), 0, rd2_data);
    end
    rd_addr = 12'o2000;
    #1;
    check("rom addr", 0, rd_rom_addr);
    check("is fixed", 1, rd_is_fixed);
    end_test();
  endtask

  task automatic test_central_regs();
    word_t vals [3];
    word_t data;
    start_test("central_regs");
    for (int i = 0; i < 3; i++) begin
      vals[i] = $random(seed);
      write_reg(all_sels[i], vals[i]);
      rd1_sel = all_sels[i];
      rd2_sel = ZERO;
      #2;
      check("bypass", vals[i], rd1_data);
      check("zero port", 0, rd2_data);
      drop_write();
      rd2_sel = all_sels[i];
      #2;
      check("rd1 stored", vals[i], rd1_data);
      check("rd2 stored", vals[i], rd2_data);
    end
    data = $random(seed);
    write_reg(ZERO, data);
    rd1_sel = ZERO;
    #2;
    check("zero bypass", 0, rd1_data);
    drop_write();
    #2;
    check("zero stored", 0, rd1_data);
    for (int i = 0; i < 3; i++) begin
      rd2_sel = all_sels[i];
      #1;
      check("held", vals[i], rd2_data);
    end
    end_test();
  endtask

  task automatic test_editing_regs();
    word_t exp_vals [4];
    word_t data;
    start_test("editing_regs");
    for (int r = 0; r < EDIT_ROUNDS; r++) begin
      for (int i = 0; i < 4; i++) begin
        data = $random(seed);
        exp_vals[i] = edit_value(all_sels[7 + i], data);
        write_reg(all_sels[7 + i], data);
        rd1_sel = all_sels[7 + i];
        #2;
        check($sformatf("bypass sel %0d", 7 + i), exp_vals[i], rd1_data);
        drop_write();
        #2;
        check($sformatf("stored sel %0d", 7 + i), exp_vals[i], rd1_data);
      end
      for (int i = 0; i < 4; i++) begin
        rd2_sel = all_sels[7 + i];
        #1;
        check($sformatf("held sel %0d", 7 + i), exp_vals[i], rd2_data);
      end
    end
    end_test();
  endtask

  task automatic test_bank_regs();
    word_t data;
    reg_sel_t sel;
    start_test("bank_regs");
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < 3; i++) begin
        sel = all_sels[3 + i];
        data = $random(seed);
        if (sel != FB) exp_eb = data[11:9];
        if (sel != EB) exp_fb = data[14:12];
        write_reg(sel, data);
        rd1_sel = sel;
        #2;
        check($sformatf("bypass sel %0d", sel), bank_word(sel), rd1_data);
        drop_write();
        for (int j = 0; j < 3; j++) begin
          rd2_sel = all_sels[3 + j];
          #1;
          check($sformatf("view sel %0d", rd2_sel), bank_word(rd2_sel), rd2_data);
        end
      end
    end
    end_test();
  endtask

  task automatic test_fixed_translate();
    logic [31:0] r;
    start_test("fixed_translate");
    for (int k = 0; k < FIXED_ROUNDS; k++) begin
      r = $random(seed);
      exp_fb = r[2:0];
      write_reg(FB, word_t'(exp_fb << 12));
      drop_write();
      for (int i = 0; i < FIXED_ADDRS; i++) begin
        r = $random(seed);
        fetch_addr = r[11:0];
        rd_addr = r[27:16];
        #2;
        check("fetch rom", expect_rom(fetch_addr, exp_fb), fetch_rom_addr);
        check("read rom", expect_rom(rd_addr, exp_fb), rd_rom_addr);
        check("is fixed", rd_addr >= 'o2000, rd_is_fixed);
        next_cycle();
      end
    end
    end_test();
  endtask

  task automatic test_erasable_mem();
    logic [31:0] r;
    soft_addr_t  banked_addr;
    word_t       banked_data;
    word_t       zero_word;
    int          mapped;
    start_test("erasable_mem");
    // Known word at RAM address 0, the write translator's RAM address for fixed space
    zero_word = $random(seed);
    mem_wr.en = 1'b1;
    mem_wr.addr = '0;
    mem_wr.data = zero_word;
    drop_write();
    for (int k = 0; k < ERAS_ROUNDS; k++) begin
      r = $random(seed);
      exp_eb = r[2:0];
      write_reg(EB, word_t'(exp_eb << 9));
      drop_write();
      // Unbanked erasable word
      r = $random(seed);
      mem_wr.en = 1'b1;
      mem_wr.addr = r[11:0] % 'o1400;
      mem_wr.data = r[30:16];
      drop_write();
      rd_addr = mem_wr.addr;
      #2;
      check("unbanked", mem_wr.data, rd_ram_data);
      if (mem_wr.addr == 0) begin
        zero_word = mem_wr.data;
      end
      // Banked erasable word
      r = $random(seed);
      banked_addr = 'o1400 + r[11:0] % 'o400;
      banked_data = r[30:16];
      mem_wr.en = 1'b1;
      mem_wr.addr = banked_addr;
      mem_wr.data = banked_data;
      drop_write();
      rd_addr = banked_addr;
      #2;
      check("banked", banked_data, rd_ram_data);
      mapped = exp_eb * 'o400 + banked_addr - 'o1400;
      if (mapped == 0) begin
        zero_word = banked_data;
      end
      if (mapped < 'o1400) begin
        rd_addr = mapped;
        #1;
        check("mapped location", banked_data, rd_ram_data);
      end
      // Write into fixed space is dropped
      r = $random(seed);
      mem_wr.en = 1'b1;
      mem_wr.addr = 'o2000 + r[11:0] % 'o6000;
      mem_wr.data = ~zero_word;
      drop_write();
      rd_addr = banked_addr;
      #1;
      check("banked word kept", banked_data, rd_ram_data);
      rd_addr = '0;
      #1;
      check("fixed write dropped", zero_word, rd_ram_data);
    end
    end_test();
  endtask

  initial begin
    seed = 32'hf819ffb7;
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    exp_eb = 0;
    exp_fb = 0;
    clk = 1'b0;
    rst_l = 1'b0;
    reg_wr = '0;
    rd1_sel = A;
    rd2_sel = A;
    fetch_addr = '0;
    rd_addr = '0;
    mem_wr = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_l = 1'b1;
    test_reset();
    test_central_regs();
    test_editing_regs();
    test_bank_regs();
    test_fixed_translate();
    test_erasable_mem();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- sources.f
hw/agc_reg_pkg.sv
hw/agc_addr_pkg.sv
hw/central_regs.sv
hw/bank_translate.sv
hw/erasable_mem.sv
hw/agc_mem_core.sv
testbench/tb_agc_mem_core.sv

//--- Bender.yml
package:
  name: agc_mem_core

sources:
  - hw/agc_reg_pkg.sv
  - hw/agc_addr_pkg.sv
  - hw/central_regs.sv
  - hw/bank_translate.sv
  - hw/erasable_mem.sv
  - hw/agc_mem_core.sv
  - target: simulation
    files:
      - testbench/tb_agc_mem_core.sv
